// ==== hw/fir_coeffs.svh ====
`ifndef FIR_COEFFS_SVH
`define FIR_COEFFS_SVH

// Half of the symmetric 64-tap window, edge to centre
localparam coeff_t COEFF_00 = 16'sd190;
localparam coeff_t COEFF_01 = 16'sd297;
localparam coeff_t COEFF_02 = 16'sd277;
localparam coeff_t COEFF_03 = 16'sd128;
localparam coeff_t COEFF_04 = -16'sd93;
localparam coeff_t COEFF_05 = -16'sd291;
localparam coeff_t COEFF_06 = -16'sd374;
localparam coeff_t COEFF_07 = -16'sd293;
localparam coeff_t COEFF_08 = -16'sd67;
localparam coeff_t COEFF_09 = 16'sd211;
localparam coeff_t COEFF_10 = 16'sd423;
localparam coeff_t COEFF_11 = 16'sd461;
localparam coeff_t COEFF_12 = 16'sd289;
localparam coeff_t COEFF_13 = -16'sd38;
localparam coeff_t COEFF_14 = -16'sd388;
localparam coeff_t COEFF_15 = -16'sd603;
localparam coeff_t COEFF_16 = -16'sd563;
localparam coeff_t COEFF_17 = -16'sd252;
localparam coeff_t COEFF_18 = 16'sd227;
localparam coeff_t COEFF_19 = 16'sd679;
localparam coeff_t COEFF_20 = 16'sd888;
localparam coeff_t COEFF_21 = 16'sd708;
localparam coeff_t COEFF_22 = 16'sd144;
localparam coeff_t COEFF_23 = -16'sd626;
localparam coeff_t COEFF_24 = -16'sd1295;
localparam coeff_t COEFF_25 = -16'sd1513;
localparam coeff_t COEFF_26 = -16'sd1024;
localparam coeff_t COEFF_27 = 16'sd235;
localparam coeff_t COEFF_28 = 16'sd2087;
localparam coeff_t COEFF_29 = 16'sd4139;
localparam coeff_t COEFF_30 = 16'sd5898;
localparam coeff_t COEFF_31 = 16'sd6911;    // Main lobe peak

`endif

// ==== hw/fir_pkg.sv ====
package fir_pkg;

        // Datapath types
        typedef logic signed [15:0] sample_t;
        typedef logic signed [15:0] coeff_t;
        typedef logic signed [16:0] fold_t;    // Sum of two mirrored samples
        typedef logic signed [31:0] acc_t;     // Products, partial sums, output

        // Central window of the low-pass prototype
        localparam int TAPS      = 64;
        localparam int HALF_TAPS = TAPS / 2;

        `include "fir_coeffs.svh"

        // Unique coefficients, outer edge of the window first, centre last.
        // Tap k and tap TAPS-1-k share COEFFS[k].
        localparam coeff_t COEFFS [HALF_TAPS] = '{
                COEFF_00,
                COEFF_01,
                COEFF_02,
                COEFF_03,
                COEFF_04,
                COEFF_05,
                COEFF_06,
                COEFF_07,
                COEFF_08,
                COEFF_09,
                COEFF_10,
                COEFF_11,
                COEFF_12,
                COEFF_13,
                COEFF_14,
                COEFF_15,
                COEFF_16,
                COEFF_17,
                COEFF_18,
                COEFF_19,
                COEFF_20,
                COEFF_21,
                COEFF_22,
                COEFF_23,
                COEFF_24,
                COEFF_25,
                COEFF_26,
                COEFF_27,
                COEFF_28,
                COEFF_29,
                COEFF_30,
                COEFF_31
        };

endpackage

// ==== hw/fir_delay_line.sv ====
`timescale 1ns/1ps

module fir_delay_line #(
        parameter int DEPTH = 64
) (
        input  logic              clk,
        input  logic              rst,
        input  fir_pkg::sample_t  sample_in,
        output fir_pkg::sample_t  taps [DEPTH]
);

        // taps[0] is the newest sample, taps[DEPTH-1] the oldest
        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < DEPTH; i++) begin
                                taps[i] <= '0;
                        end
                end else begin
                        taps[0] <= sample_in;
                        for (int i = 1; i < DEPTH; i++) begin
                                taps[i] <= taps[i-1];    // One stage per clock
                        end
                end
        end

endmodule

// ==== hw/fir_fold_mult.sv ====
`timescale 1ns/1ps

module fir_fold_mult (
        input  logic              clk,
        input  logic              rst,
        input  fir_pkg::sample_t  taps     [fir_pkg::TAPS],
        output fir_pkg::acc_t     products [fir_pkg::HALF_TAPS]
);

        fir_pkg::fold_t folded  [fir_pkg::HALF_TAPS];
        fir_pkg::acc_t  product [fir_pkg::HALF_TAPS];

        // Pre-add mirrored taps, one extra bit keeps the sum exact
        always_comb begin
                for (int k = 0; k < fir_pkg::HALF_TAPS; k++) begin
                        folded[k] = fir_pkg::fold_t'(taps[k])
                                  + fir_pkg::fold_t'(taps[fir_pkg::TAPS-1-k]);
                end
        end

        // 17 x 16 bit signed product, fits in 32 bits
        always_comb begin
                for (int k = 0; k < fir_pkg::HALF_TAPS; k++) begin
                        product[k] = fir_pkg::acc_t'(folded[k])
                                   * fir_pkg::acc_t'(fir_pkg::COEFFS[k]);
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int k = 0; k < fir_pkg::HALF_TAPS; k++) begin
                                products[k] <= '0;
                        end
                end else begin
                        for (int k = 0; k < fir_pkg::HALF_TAPS; k++) begin
                                products[k] <= product[k];
                        end
                end
        end

endmodule

// ==== hw/fir_adder_tree.sv ====
`timescale 1ns/1ps

module fir_adder_tree #(
        parameter int N_INPUTS = 32    // Power of two, at least 2
) (
        input  logic           clk,
        input  logic           rst,
        input  fir_pkg::acc_t  terms [N_INPUTS],
        output fir_pkg::acc_t  sum
);

        // Internal nodes of a complete binary tree, stored heap style.
        // Node i has children 2i+1 and 2i+2. Indices from N_INPUTS-1 upward
        // are the leaves, which are the input terms themselves.
        localparam int N_NODES = N_INPUTS - 1;

        fir_pkg::acc_t node [N_NODES];

        for (genvar i = 0; i < N_NODES; i++) begin : g_node
                localparam int LEFT  = 2 * i + 1;
                localparam int RIGHT = 2 * i + 2;

                if (LEFT >= N_NODES) begin : g_bottom
                        // First level, adds input terms
                        always_ff @(posedge clk) begin
                                if (rst) begin
                                        node[i] <= '0;
                                end else begin
                                        node[i] <= terms[LEFT-N_NODES] + terms[RIGHT-N_NODES];
                                end
                        end
                end else begin : g_upper
                        always_ff @(posedge clk) begin
                                if (rst) begin
                                        node[i] <= '0;
                                end else begin
                                        node[i] <= node[LEFT] + node[RIGHT];
                                end
                        end
                end
        end

        // Root, log2(N_INPUTS) registers behind the terms
        assign sum = node[0];

endmodule

// ==== hw/fir_top.sv ====
`timescale 1ns/1ps

module fir_top (
        input  logic              clk,
        input  logic              rst,
        input  fir_pkg::sample_t  data_in,
        output fir_pkg::acc_t     data_out
);

        fir_pkg::sample_t taps     [fir_pkg::TAPS];
        fir_pkg::acc_t    products [fir_pkg::HALF_TAPS];

        // Sample history, one new sample every clock
        fir_delay_line #(
                .DEPTH     (fir_pkg::TAPS)
        ) u_delay_line (
                .clk       (clk),
                .rst       (rst),
                .sample_in (data_in),
                .taps      (taps)
        );

        // Symmetric pre-add and coefficient multiply, 1 cycle
        fir_fold_mult u_fold_mult (
                .clk       (clk),
                .rst       (rst),
                .taps      (taps),
                .products  (products)
        );

        // 5 cycles for 32 products
        fir_adder_tree #(
                .N_INPUTS  (fir_pkg::HALF_TAPS)
        ) u_adder_tree (
                .clk       (clk),
                .rst       (rst),
                .terms     (products),
                .sum       (data_out)
        );

endmodule

// ==== dv/fir_tb_model.svh ====
`ifndef FIR_TB_MODEL_SVH
`define FIR_TB_MODEL_SVH

// Reference model of the 64-tap filter, kept one drive edge ahead of the DUT

fir_pkg::sample_t history [fir_pkg::TAPS];    // history[0] is the newest sample
fir_pkg::acc_t    exp_q   [$];                // Expected outputs, oldest first
logic [15:0]      lfsr_state = 16'd23529;

// Tap k of the full impulse response, mirrored about the centre
function automatic fir_pkg::coeff_t full_coeff(input int k);
        if (k < fir_pkg::HALF_TAPS) begin
                return fir_pkg::COEFFS[k];
        end
        return fir_pkg::COEFFS[fir_pkg::TAPS-1-k];
endfunction

// DC gain of the filter
function automatic longint coeff_total();
        longint total;
        total = 0;
        for (int k = 0; k < fir_pkg::TAPS; k++) begin
                total += longint'(full_coeff(k));
        end
        return total;
endfunction

// Empty pipeline, as after reset
function automatic void clear_history();
        for (int k = 0; k < fir_pkg::TAPS; k++) begin
                history[k] = '0;
        end
        exp_q.delete();
        for (int k = 0; k < QUEUE_LEN; k++) begin
                exp_q.push_back('0);
        end
endfunction

// Direct convolution over the history, exact in 64 bits
function automatic void push_sample(input fir_pkg::sample_t s);
        longint acc;
        for (int k = fir_pkg::TAPS - 1; k > 0; k--) begin
                history[k] = history[k-1];
        end
        history[0] = s;
        acc = 0;
        for (int k = 0; k < fir_pkg::TAPS; k++) begin
                acc += longint'(history[k]) * longint'(full_coeff(k));
        end
        // True sum has to fit the 32-bit output without wrapping
        if (acc != longint'(fir_pkg::acc_t'(acc))) begin
                $display("Done: errors found");
                $fatal(1, "Expected filter output %0d does not fit in 32 bits", acc);
        end
        exp_q.push_back(fir_pkg::acc_t'(acc));
        if (exp_q.size() > QUEUE_LEN) begin
                void'(exp_q.pop_front());
        end
endfunction

// x^16 + x^14 + x^13 + x^11, Fibonacci form
function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
endfunction

function automatic fir_pkg::sample_t random_sample();
        fir_pkg::sample_t s;
        s = '0;
        for (int i = 0; i < 16; i++) begin
                s = {s[14:0], lfsr_bit()};    // One LFSR step per bit
        end
        return s;
endfunction

task automatic check_acc(input string name, input fir_pkg::acc_t expected,
                         input fir_pkg::acc_t actual);
        if (actual !== expected) begin
                $display("Error: test %s, expected %0d, actual %0d", name, expected, actual);
                $display("Done: errors found");
                $fatal(1, "Filter output mismatch");
        end
endtask

`endif

// ==== dv/fir_tb.sv ====
`timescale 1ns/1ps

module fir_tb;

        localparam int CLK_PERIOD   = 20;
        localparam int RESET_CYCLES = 4;
        localparam int LATENCY      = 6;              // Sample taken to data_out
        localparam int QUEUE_LEN    = LATENCY + 2;    // One more for the drive edge

        typedef enum int {
                KIND_CONST,
                KIND_IMPULSE,
                KIND_ALT,
                KIND_RAND
        } kind_t;

        typedef struct {
                string name;
                kind_t kind;
                int    amplitude;
                int    cycles;
                bit    reset_first;
        } test_row_t;

        localparam int N_ROWS = 9;

        // Name, input kind, amplitude, cycles, reset before the row
        test_row_t rows [N_ROWS] = '{
                '{"zero_after_reset", KIND_CONST,   0,      80,  1'b0},
                '{"impulse",          KIND_IMPULSE, 1,      80,  1'b0},
                '{"impulse_min",      KIND_IMPULSE, -32768, 80,  1'b0},
                '{"constant",         KIND_CONST,   1000,   100, 1'b0},
                '{"constant_max",     KIND_CONST,   32767,  100, 1'b0},
                '{"constant_min",     KIND_CONST,   -32768, 100, 1'b0},
                '{"alternating",      KIND_ALT,     32767,  100, 1'b0},
                '{"random",           KIND_RAND,    0,      300, 1'b0},
                '{"reset_mid_stream", KIND_RAND,    0,      100, 1'b1}
        };

        logic             clk;
        logic             rst;
        fir_pkg::sample_t data_in;
        fir_pkg::acc_t    data_out;
        logic             check_en;
        string            cur_test;

        `include "fir_tb_model.svh"

        fir_top DUT (
                .clk      (clk),
                .rst      (rst),
                .data_in  (data_in),
                .data_out (data_out)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #(CLK_PERIOD / 2) clk = ~clk;
                end
        end

        // Sample n of a table row
        function automatic fir_pkg::sample_t make_sample(input test_row_t row, input int n);
                case (row.kind)
                        KIND_CONST: begin
                                return fir_pkg::sample_t'(row.amplitude);
                        end
                        KIND_IMPULSE: begin
                                if (n == 0) begin
                                        return fir_pkg::sample_t'(row.amplitude);
                                end
                                return '0;
                        end
                        KIND_ALT: begin
                                if (n % 2 == 0) begin
                                        return fir_pkg::sample_t'(row.amplitude);
                                end
                                return fir_pkg::sample_t'(-row.amplitude - 1);
                        end
                        default: begin
                                return random_sample();
                        end
                endcase
        endfunction

        task automatic drive_sample(input fir_pkg::sample_t s);
                @(posedge clk);
                data_in <= s;
                push_sample(s);
        endtask

        task automatic apply_reset(input string name);
                check_en = 1'b0;
                @(posedge clk);
                rst     <= 1'b1;
                data_in <= '0;
                repeat (RESET_CYCLES - 1) begin
                        @(posedge clk);
                end
                @(negedge clk);
                check_acc({name, " reset"}, '0, data_out);    // Cleared while held
                @(posedge clk);
                rst <= 1'b0;
                clear_history();
                check_en = 1'b1;
        endtask

        // Impulse response read straight off the coefficient table
        task automatic check_impulse_step(input test_row_t row, input int n);
                fir_pkg::acc_t expected;
                int            k;
                k = n - LATENCY - 1;
                expected = '0;
                if (k >= 0 && k < fir_pkg::TAPS) begin
                        expected = fir_pkg::acc_t'(longint'(row.amplitude)
                                                   * longint'(full_coeff(k)));
                end
                @(negedge clk);
                check_acc({row.name, " coefficient"}, expected, data_out);
        endtask

        // Final value once the whole window holds the row's own samples
        task automatic check_settled(input test_row_t row);
                fir_pkg::acc_t expected;
                if (row.kind == KIND_CONST) begin
                        expected = fir_pkg::acc_t'(longint'(row.amplitude) * coeff_total());
                end else if (row.kind == KIND_IMPULSE) begin
                        expected = '0;
                end else begin
                        return;
                end
                @(negedge clk);
                check_acc({row.name, " settled"}, expected, data_out);
        endtask

        // Cycle by cycle compare against the model
        always @(negedge clk) begin
                if (check_en && exp_q.size() == QUEUE_LEN) begin
                        check_acc(cur_test, exp_q[0], data_out);
                end
        end

        initial begin
                rst      = 1'b1;
                data_in  = '0;
                check_en = 1'b0;
                cur_test = "initial";

                apply_reset("initial");

                for (int r = 0; r < N_ROWS; r++) begin
                        cur_test = rows[r].name;
                        if (rows[r].reset_first) begin
                                apply_reset(rows[r].name);
                        end
                        for (int n = 0; n < rows[r].cycles; n++) begin
                                drive_sample(make_sample(rows[r], n));
                                if (rows[r].kind == KIND_IMPULSE) begin
                                        check_impulse_step(rows[r], n);
                                end
                        end
                        check_settled(rows[r]);
                end

                // Drain so the last samples reach data_out
                cur_test = "drain";
                repeat (LATENCY + 1) begin
                        drive_sample('0);
                end
                @(posedge clk);

                $display("Done: no errors");
                $finish;
        end

        // Watchdog
        initial begin
                longint limit_ns;
                int     total;
                int     n_resets;
                total    = 0;
                n_resets = 1;
                for (int r = 0; r < N_ROWS; r++) begin
                        total += rows[r].cycles;
                        if (rows[r].reset_first) begin
                                n_resets++;
                        end
                end
                limit_ns = longint'(2 * total + RESET_CYCLES * n_resets + LATENCY + 1)
                           * CLK_PERIOD;
                #(limit_ns);
                $display("Done: errors found");
                $fatal(1, "Timeout, simulation still running after %0d ns", limit_ns);
        end

endmodule

// ==== vlog.f ====
+incdir+hw
+incdir+dv
hw/fir_pkg.sv
hw/fir_delay_line.sv
hw/fir_fold_mult.sv
hw/fir_adder_tree.sv
hw/fir_top.sv
dv/fir_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the FIR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f vlog.f \
    --top-module fir_tb \
    -Mdir obj_dir \
    -o fir_sim

# The simulator exits non-zero on failure; the output is searched either way
out=$(./obj_dir/fir_sim 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Done: no errors'; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
